// File: Makefile
# Verilator build and run of the histogram builder testbench.

VERILATOR ?= verilator
TOP       ?= tb_sifh_hist
FILELIST  ?= sifh_hist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# the run passes only if the pass message shows up in the output.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: apb_hist_regs.sv
`timescale 1ns/1ps
`include "sifh_hist_defines.svh"

module apb_hist_regs (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [11:0]              paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output sifh_hist_pkg::hit_cnt_t  hits_per_acq,
    output sifh_hist_pkg::acq_t      acq_target,
    output logic                     arm,
    output logic                     clear_start,
    input  sifh_hist_pkg::acq_t      acq_count,
    input  logic                     done,
    input  logic                     clear_busy,
    output sifh_hist_pkg::bin_t      rd_bin,
    input  sifh_hist_pkg::count_t    rd_data
);
    import sifh_hist_pkg::*;

    logic        access;
    logic        wr_en;
    logic        ctrl_go;
    logic        bin_sel;
    logic        bin_rd;
    logic        bin_wait;
    logic        reg_hit;
    logic [31:0] reg_rdata;
    logic [11:0] bin_off;

    assign access  = psel && penable;
    assign bin_sel = (paddr >= `SIFH_BIN_BASE) &&
                     (paddr < 12'(`SIFH_BIN_BASE + 4 * `SIFH_BIN_NUM));
    assign bin_off = paddr - `SIFH_BIN_BASE;
    assign rd_bin  = bin_off[`SIFH_BIN_W+1:2];  // word address.
    assign bin_rd  = bin_sel && !pwrite;

    ////////////////////////////////////////////////////////////
    // register decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (paddr)
            CTRL:         reg_rdata = '0;  // command only.
            STATUS:       reg_rdata = {30'b0, clear_busy, done};
            HITS_PER_ACQ: reg_rdata = 32'(hits_per_acq);
            ACQ_TARGET:   reg_rdata = 32'(acq_target);
            ACQ_COUNT:    reg_rdata = 32'(acq_count);
            default:      reg_hit = 1'b0;
        endcase
    end

    assign wr_en   = access && pwrite && reg_hit;
    assign ctrl_go = wr_en && (paddr == CTRL) && pwdata[0];

    // clear and re-arm go out together.
    assign arm         = ctrl_go;
    assign clear_start = ctrl_go;

    // bin reads wait one cycle for the memory.
    assign pready  = access && (!bin_rd || bin_wait);
    assign pslverr = access && !(reg_hit || bin_rd);
    assign prdata  = bin_sel ? 32'(rd_data) : reg_rdata;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hits_per_acq <= hit_cnt_t'(1);
            acq_target   <= acq_t'(1);
            bin_wait     <= 1'b0;
        end else begin
            bin_wait <= access && bin_rd && !bin_wait;
            if (wr_en && (paddr == HITS_PER_ACQ)) begin
                hits_per_acq <= pwdata[`SIFH_HIT_CNT_W-1:0];
            end
            if (wr_en && (paddr == ACQ_TARGET)) begin
                acq_target <= pwdata[`SIFH_ACQ_W-1:0];
            end
        end
    end

endmodule

// File: bin_accumulator.sv
`timescale 1ns/1ps
`include "sifh_hist_defines.svh"

module bin_accumulator (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   acc_valid,
    input  logic                   last_hit,
    input  sifh_hist_pkg::bin_t    acc_bin,
    input  logic                   clear_start,
    output logic                   clear_busy,
    output logic                   done,
    input  sifh_hist_pkg::bin_t    rd_bin,
    output sifh_hist_pkg::count_t  rd_data
);
    import sifh_hist_pkg::*;

    count_t mem [`SIFH_BIN_NUM];

    // stage 2, old count read from memory.
    logic   s2_valid;
    logic   s2_last;
    bin_t   s2_bin;
    count_t s2_rdata;

    // write-back record of the previous cycle.
    logic   wb_valid;
    logic   wb_last;
    bin_t   wb_bin;
    count_t wb_count;

    count_t s2_old;
    count_t s2_new;
    bin_t   clr_addr;

    // a read issued while the older hit was writing sees stale data.
    assign s2_old = (wb_valid && (wb_bin == s2_bin)) ? wb_count : s2_rdata;
    assign s2_new = (s2_old == '1) ? s2_old : count_t'(s2_old + 1'b1);  // saturate.

    ////////////////////////////////////////////////////////////
    // pipeline valids
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
            wb_valid <= 1'b0;
            wb_last  <= 1'b0;
        end else if (clear_start) begin
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
            wb_valid <= 1'b0;
            wb_last  <= 1'b0;
        end else begin
            s2_valid <= acc_valid;
            s2_last  <= acc_valid && last_hit;
            wb_valid <= s2_valid;
            wb_last  <= s2_valid && s2_last;
        end
    end

    always_ff @(posedge clk) begin
        s2_bin   <= acc_bin;
        s2_rdata <= mem[acc_bin];  // old data on a same-edge write.
        wb_bin   <= s2_bin;
        wb_count <= s2_new;
    end

    ////////////////////////////////////////////////////////////
    // clear sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clear_busy <= 1'b1;  // wipe after reset.
            clr_addr   <= '0;
        end else if (clear_start) begin
            clear_busy <= 1'b1;
            clr_addr   <= '0;
        end else if (clear_busy) begin
            clr_addr <= bin_t'(clr_addr + 1'b1);
            if (clr_addr == bin_t'(`SIFH_BIN_NUM - 1)) begin
                clear_busy <= 1'b0;
            end
        end
    end

    // one write port, clear first.
    always_ff @(posedge clk) begin
        if (clear_busy) begin
            mem[clr_addr] <= '0;
        end else if (s2_valid) begin
            mem[s2_bin] <= s2_new;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_bin];  // readout port.
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            done <= 1'b0;
        end else if (clear_start) begin
            done <= 1'b0;
        end else if (wb_valid && wb_last) begin
            done <= 1'b1;  // final hit is in memory.
        end
    end

endmodule

// File: sample_gate.sv
`timescale 1ns/1ps

module sample_gate (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     hit_valid,
    input  sifh_hist_pkg::bin_t      hit_bin,
    output logic                     hit_ready,
    input  sifh_hist_pkg::hit_cnt_t  hits_per_acq,
    input  sifh_hist_pkg::acq_t      acq_target,
    input  logic                     arm,
    input  logic                     clear_busy,
    output logic                     acc_valid,
    output logic                     last_hit,
    output sifh_hist_pkg::bin_t      acc_bin,
    output sifh_hist_pkg::acq_t      acq_count
);
    import sifh_hist_pkg::*;

    hit_cnt_t hit_cnt;
    hit_cnt_t hpa_eff;
    acq_t     tgt_eff;
    logic     frozen;
    logic     accept;
    logic     acq_end;
    logic     run_end;

    // zero settings behave as one.
    assign hpa_eff = (hits_per_acq == '0) ? hit_cnt_t'(1) : hits_per_acq;
    assign tgt_eff = (acq_target == '0) ? acq_t'(1) : acq_target;

    assign hit_ready = !clear_busy && !frozen && !arm;
    assign accept    = hit_valid && hit_ready;

    assign acq_end = (hit_cnt >= hpa_eff - hit_cnt_t'(1));            // completes acquisition.
    assign run_end = acq_end && (acq_count >= tgt_eff - acq_t'(1));  // completes the run.

    ////////////////////////////////////////////////////////////
    // stage 1 control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt   <= '0;
            acq_count <= '0;
            frozen    <= 1'b0;
            acc_valid <= 1'b0;
            last_hit  <= 1'b0;
        end else if (arm) begin
            // new run, drop anything not yet issued.
            hit_cnt   <= '0;
            acq_count <= '0;
            frozen    <= 1'b0;
            acc_valid <= 1'b0;
            last_hit  <= 1'b0;
        end else begin
            acc_valid <= accept;
            last_hit  <= accept && run_end;
            if (accept) begin
                if (acq_end) begin
                    hit_cnt   <= '0;
                    acq_count <= acq_t'(acq_count + 1'b1);
                    frozen    <= run_end;  // hold until re-armed.
                end else begin
                    hit_cnt <= hit_cnt_t'(hit_cnt + 1'b1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_bin <= hit_bin;
        end
    end

endmodule

// File: sifh_hist.f
+incdir+.
sifh_hist_pkg.sv
sample_gate.sv
bin_accumulator.sv
apb_hist_regs.sv
sifh_hist_top.sv
tb_sifh_hist.sv

// File: sifh_hist_defines.svh
`ifndef SIFH_HIST_DEFINES_SVH
`define SIFH_HIST_DEFINES_SVH

////////////////////////////////////////////////////////////
// histogram geometry
////////////////////////////////////////////////////////////

// bin index width for 64 bins.
`define SIFH_BIN_W 6
`define SIFH_BIN_NUM 64

// one counter per bin.
`define SIFH_COUNT_W 16

////////////////////////////////////////////////////////////
// acquisition control
////////////////////////////////////////////////////////////

`define SIFH_HIT_CNT_W 8  // hits per acquisition.
`define SIFH_ACQ_W 20     // acquisition target and counter.

////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////

// bin n is read at base + 4*n.
`define SIFH_BIN_BASE 12'h100

`endif

// File: sifh_hist_pkg.sv
`include "sifh_hist_defines.svh"

package sifh_hist_pkg;

    // bin index into the histogram memory.
    typedef logic [`SIFH_BIN_W-1:0] bin_t;

    // saturating bin count.
    typedef logic [`SIFH_COUNT_W-1:0] count_t;

    // acquisition number and target.
    typedef logic [`SIFH_ACQ_W-1:0] acq_t;

    // hits that make up one acquisition.
    typedef logic [`SIFH_HIT_CNT_W-1:0] hit_cnt_t;

    ////////////////////////////////////////////////////////////
    // register offsets, below the bin window
    ////////////////////////////////////////////////////////////
    typedef enum logic [11:0] {
        CTRL         = 12'h000,  // bit 0 clears and re-arms.
        STATUS       = 12'h004,  // bit 0 done, bit 1 busy.
        HITS_PER_ACQ = 12'h008,
        ACQ_TARGET   = 12'h00C,
        ACQ_COUNT    = 12'h010
    } reg_off_e;

endpackage

// File: sifh_hist_stim.txt
# columns: cmd, then hex fields. W offset data, R offset expected, H bin count
# D wait done and check bins, C wait clear and check bins, X bin cycles held while frozen
C
R 004 00000000
R 010 00000000
R 008 00000001
R 00C 00000001
R 020 00000000
R 002 00000000
W 008 00000004
W 00C 00000003
R 008 00000004
R 00C 00000003
H 05 4
H 05 1
H 06 1
H 05 1
H 06 1
H 07 2
H 05 1
H 3F 1
D
R 010 00000003
R 004 00000001
X 05 32
W 000 00000001
C
R 010 00000000
H 00 5
H 3F 7
D
W 008 000000FF
W 00C 00000102
R 008 000000FF
R 00C 00000102
W 000 00000001
C
H 0A 100FE
D
R 010 00000102
R 004 00000001
W 000 00000001
C
R 004 00000000

// File: sifh_hist_top.sv
`timescale 1ns/1ps

module sifh_hist_top (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 hit_valid,
    input  sifh_hist_pkg::bin_t  hit_bin,
    output logic                 hit_ready,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [11:0]          paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr
);
    import sifh_hist_pkg::*;

    logic     acc_valid;
    logic     last_hit;
    bin_t     acc_bin;
    logic     clear_busy;
    logic     done;
    hit_cnt_t hits_per_acq;
    acq_t     acq_target;
    acq_t     acq_count;
    logic     arm;
    logic     clear_start;
    bin_t     rd_bin;
    count_t   rd_data;

    ////////////////////////////////////////////////////////////
    // stage 1, gating
    ////////////////////////////////////////////////////////////
    sample_gate u_gate (
        .clk          (clk),
        .res          (res),
        .hit_valid    (hit_valid),
        .hit_bin      (hit_bin),
        .hit_ready    (hit_ready),
        .hits_per_acq (hits_per_acq),
        .acq_target   (acq_target),
        .arm          (arm),
        .clear_busy   (clear_busy),
        .acc_valid    (acc_valid),
        .last_hit     (last_hit),
        .acc_bin      (acc_bin),
        .acq_count    (acq_count)
    );

    // stages 2 and 3.
    bin_accumulator u_acc (
        .clk         (clk),
        .res         (res),
        .acc_valid   (acc_valid),
        .last_hit    (last_hit),
        .acc_bin     (acc_bin),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .done        (done),
        .rd_bin      (rd_bin),
        .rd_data     (rd_data)
    );

    apb_hist_regs u_regs (
        .clk          (clk),
        .res          (res),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .hits_per_acq (hits_per_acq),
        .acq_target   (acq_target),
        .arm          (arm),
        .clear_start  (clear_start),
        .acq_count    (acq_count),
        .done         (done),
        .clear_busy   (clear_busy),
        .rd_bin       (rd_bin),
        .rd_data      (rd_data)
    );

endmodule

// File: tb_sifh_hist.sv
`timescale 1ns/1ps
`include "sifh_hist_defines.svh"

module tb_sifh_hist;

    logic                    clk;
    logic                    res;
    logic                    hit_valid;
    logic [`SIFH_BIN_W-1:0]  hit_bin;
    logic                    hit_ready;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [11:0]             paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    logic [`SIFH_COUNT_W-1:0] model [`SIFH_BIN_NUM];  // expected bin counts.
    logic [31:0]              rng_state;
    int                       budget;

    sifh_hist_top dut_i (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_bin   (hit_bin),
        .hit_ready (hit_ready),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // budget is known once the script has been scanned.
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        report_fail("timeout: the stim script did not finish within the cycle budget");
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < `SIFH_BIN_NUM; i++) begin
            model[i] = '0;
        end
    endfunction

    function automatic bit in_bin_window(input logic [11:0] off);
        return (off >= `SIFH_BIN_BASE) &&
               (off < 12'(`SIFH_BIN_BASE + 4 * `SIFH_BIN_NUM));
    endfunction

    // the bin window only takes reads.
    function automatic bit is_mapped(input logic [11:0] off, input bit write);
        if (off == 12'h000 || off == 12'h004 || off == 12'h008 ||
            off == 12'h00C || off == 12'h010) begin
            return 1'b1;
        end
        return !write && in_bin_window(off);
    endfunction

    function automatic bit parse_line(input string line, output byte cmd,
                                      output logic [31:0] a, output logic [31:0] b);
        int n;
        a   = 32'h0;
        b   = 32'h0;
        cmd = 8'h0;
        if (line.len() == 0) return 1'b0;
        cmd = line.getc(0);
        if (cmd == "#" || cmd == " " || cmd == "\n" || cmd == "\r") return 1'b0;
        if (line.len() > 1) n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        return 1'b1;
    endfunction

    task automatic apb_xfer(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        int exp_waits;
        exp_waits = (!write && in_bin_window(addr)) ? 1 : 0;  // bin reads wait once.
        waits     = 0;
        @(posedge clk);
        hit_valid <= 1'b0;  // hits idle during register access.
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= write;
        paddr     <= addr;
        pwdata    <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits = waits + 1;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        assert (waits == exp_waits) else
            report_fail($sformatf("[ERROR] pready waits at 0x%h: got 0x%h, expected 0x%h",
                                  addr, waits, exp_waits));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic send_hits(input logic [`SIFH_BIN_W-1:0] bin, input int count);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            hit_bin   <= bin;
            hit_valid <= (next_rand() & 32'h7) != 32'h0;  // random idle cycles.
            @(negedge clk);
            if (hit_valid && hit_ready) begin
                sent = sent + 1;
                if (model[bin] != {`SIFH_COUNT_W{1'b1}}) model[bin] = model[bin] + 1'b1;
            end
        end
    endtask

    task automatic hold_blocked(input logic [`SIFH_BIN_W-1:0] bin, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            hit_bin   <= bin;
            hit_valid <= 1'b1;
            @(negedge clk);
            assert (!hit_ready) else
                report_fail($sformatf("[ERROR] hit_ready while frozen: got 0x%h, expected 0x0",
                                      hit_ready));
        end
    endtask

    task automatic wait_status(input int bit_idx, input logic want);
        logic [31:0] rdata;
        logic        err;
        rdata = 32'h0;
        do begin
            apb_xfer(1'b0, 12'h004, 32'h0, rdata, err);
            assert (!err) else report_fail("[ERROR] pslverr on STATUS: got 0x1, expected 0x0");
        end while (rdata[bit_idx] != want);
    endtask

    task automatic check_bins();
        logic [31:0] rdata;
        logic        err;
        logic [11:0] addr;
        for (int i = 0; i < `SIFH_BIN_NUM; i++) begin
            addr = 12'(`SIFH_BIN_BASE + 4 * i);
            apb_xfer(1'b0, addr, 32'h0, rdata, err);
            assert (!err) else
                report_fail($sformatf("[ERROR] pslverr on bin %0d: got 0x1, expected 0x0", i));
            assert (rdata == 32'(model[i])) else
                report_fail($sformatf("[ERROR] prdata for bin %0d: got 0x%h, expected 0x%h",
                                      i, rdata, 32'(model[i])));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // script commands
    ////////////////////////////////////////////////////////////
    task automatic run_command(input byte cmd, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] rdata;
        logic        err;
        logic        exp_err;
        case (cmd)
            "W": begin
                apb_xfer(1'b1, a[11:0], b, rdata, err);
                exp_err = !is_mapped(a[11:0], 1'b1);
                assert (err == exp_err) else
                    report_fail($sformatf("[ERROR] pslverr at 0x%h: got 0x%h, expected 0x%h",
                                          a[11:0], err, exp_err));
                if (a[11:0] == 12'h000 && b[0]) clear_model();  // memory wiped.
            end
            "R": begin
                apb_xfer(1'b0, a[11:0], 32'h0, rdata, err);
                exp_err = !is_mapped(a[11:0], 1'b0);
                assert (err == exp_err) else
                    report_fail($sformatf("[ERROR] pslverr at 0x%h: got 0x%h, expected 0x%h",
                                          a[11:0], err, exp_err));
                if (!err) begin
                    assert (rdata == b) else
                        report_fail($sformatf("[ERROR] prdata at 0x%h: got 0x%h, expected 0x%h",
                                              a[11:0], rdata, b));
                end
            end
            "H": send_hits(a[`SIFH_BIN_W-1:0], int'(b));
            "D": begin
                wait_status(0, 1'b1);
                check_bins();
            end
            "C": begin
                wait_status(1, 1'b0);
                check_bins();
            end
            "X": begin
                hold_blocked(a[`SIFH_BIN_W-1:0], int'(b));
                check_bins();
            end
            default: assert (1'b0) else
                report_fail($sformatf("unknown command '%c' in the stim script", cmd));
        endcase
    endtask

    initial begin
        int          fd;
        int          n;
        int          lines;
        int          hits;
        int          sweeps;
        string       line;
        byte         cmd;
        logic [31:0] a;
        logic [31:0] b;
        hit_valid <= 1'b0;
        hit_bin   <= '0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        res       <= 1'b0;
        rng_state = 32'd67870;
        budget    = 0;
        lines     = 0;
        hits      = 0;
        sweeps    = 0;
        clear_model();

        // first pass sizes the watchdog.
        fd = $fopen("sifh_hist_stim.txt", "r");
        assert (fd != 0) else report_fail("could not open sifh_hist_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && parse_line(line, cmd, a, b)) begin
                lines = lines + 1;
                if (cmd == "H" || cmd == "X") hits = hits + int'(b);
                if (cmd == "D" || cmd == "C" || cmd == "X") sweeps = sweeps + 1;
            end
        end
        $fclose(fd);
        budget = 200 * lines + 2000 + 2 * hits + 300 * sweeps;

        repeat (3) @(posedge clk);
        res <= 1'b1;

        fd = $fopen("sifh_hist_stim.txt", "r");
        assert (fd != 0) else report_fail("could not reopen sifh_hist_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && parse_line(line, cmd, a, b)) run_command(cmd, a, b);
        end
        $fclose(fd);

        @(posedge clk);
        hit_valid <= 1'b0;
        $display("Verification passed");
        $finish;
    end

endmodule
